/* Makefile */
VERILATOR ?= verilator
TOP ?= led_ctrl_tb
FLAGS ?= --binary --timing --assert -Wno-fatal

FILELIST := led_ctrl.f
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard logic/*.svh)
BIN := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Test OK"

clean:
	rm -rf obj_dir

/* led_ctrl.f */
+incdir+logic
logic/led_cmd_pkg.sv
logic/led_fb_pkg.sv
logic/led_cmd_dispatch.sv
logic/pixel_writer.sv
logic/panel_filler.sv
logic/fb_bus_arbiter.sv
logic/led_ctrl_top.sv
tb/led_ctrl_assert.sv
tb/led_ctrl_tb.sv

/* logic/fb_bus_arbiter.sv */
/*
 * Frame buffer bus arbiter
 * Fixed priority, master 0 first, grant held for a whole Wishbone cycle.
 */
`timescale 1ns/1ps

module fb_bus_arbiter (
    input  logic                 clk_in,
    input  logic                 reset,
    input  logic                 m0_cyc,
    input  logic                 m0_stb,
    input  led_fb_pkg::fb_addr_t m0_adr,
    input  led_fb_pkg::fb_data_t m0_dat,
    output logic                 m0_ack,
    input  logic                 m1_cyc,
    input  logic                 m1_stb,
    input  led_fb_pkg::fb_addr_t m1_adr,
    input  led_fb_pkg::fb_data_t m1_dat,
    output logic                 m1_ack,
    output logic                 fb_cyc,
    output logic                 fb_stb,
    output logic                 fb_we,
    output led_fb_pkg::fb_addr_t fb_adr,
    output led_fb_pkg::fb_data_t fb_dat,
    input  logic                 fb_ack
);
    logic grant;
    logic hold;
    logic sel;

    // granted master still in its cycle
    assign hold = grant ? m1_cyc : m0_cyc;
    assign sel = hold ? grant : !m0_cyc;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            grant <= 1'b0;
        end else begin
            grant <= sel;
        end
    end

    assign fb_cyc = sel ? m1_cyc : m0_cyc;
    assign fb_stb = sel ? m1_stb : m0_stb;
    // write only bus
    assign fb_we = fb_cyc;
    assign fb_adr = sel ? m1_adr : m0_adr;
    assign fb_dat = sel ? m1_dat : m0_dat;
    assign m0_ack = fb_ack && !sel;
    assign m1_ack = fb_ack && sel;

endmodule

/* logic/led_cmd_dispatch.sv */
/*
 * Command dispatcher
 * Decodes opcodes, holds colour and brightness state, feeds the frame buffer writers.
 */
`timescale 1ns/1ps
`include "led_ctrl_config.svh"

module led_cmd_dispatch (
    input  logic                    clk_in,
    input  logic                    reset,
    input  led_cmd_pkg::cmd_byte_t  rx_data,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    input  logic                    pixel_ready,
    input  logic                    pixel_done,
    input  logic                    fill_ready,
    input  logic                    fill_done,
    output logic                    busy,
    output logic [2:0]              rgb_enable,
    output led_fb_pkg::brightness_t brightness_enable,
    output led_cmd_pkg::cmd_byte_t  byte_data,
    output logic                    pixel_start,
    output logic                    pixel_byte,
    output logic                    fill_start,
    output logic                    blank_start,
    output logic                    fill_byte
);
    typedef enum logic [1:0] {
        IDLE,
        BRIGHTNESS,
        PIXEL,
        FILL
    } ctrl_state_e;

    ctrl_state_e state;
    led_cmd_pkg::opcode_e opcode;
    logic take;
    logic idle_take;
    led_fb_pkg::brightness_t toggle_mask;

    assign opcode = led_cmd_pkg::opcode_e'(rx_data);
    assign take = rx_valid && rx_ready;
    assign idle_take = take && (state == IDLE);

    // writer states follow the writer's own ready
    always_comb begin
        case (state)
            PIXEL:   rx_ready = pixel_ready;
            FILL:    rx_ready = fill_ready;
            default: rx_ready = 1'b1;
        endcase
    end

    assign busy = (state == PIXEL) || (state == FILL);

    assign byte_data = rx_data;
    assign pixel_start = idle_take && (opcode == led_cmd_pkg::READPIXEL);
    assign fill_start = idle_take && (opcode == led_cmd_pkg::FILLPANEL);
    assign blank_start = idle_take && (opcode == led_cmd_pkg::BLANKPANEL);
    assign pixel_byte = take && (state == PIXEL);
    assign fill_byte = take && (state == FILL);

    // BRIGHTNESS_ONE hits the top bit, SIX the bottom
    assign toggle_mask = led_fb_pkg::brightness_t'(1)
                         << (`LED_BRIGHTNESS_LEVELS - int'(rx_data[3:0]));

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= IDLE;
            rgb_enable <= 3'b111;
            brightness_enable <= '1;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        case (opcode)
                            led_cmd_pkg::RED_ENABLE:      rgb_enable[0] <= 1'b1;
                            led_cmd_pkg::RED_DISABLE:     rgb_enable[0] <= 1'b0;
                            led_cmd_pkg::GREEN_ENABLE:    rgb_enable[1] <= 1'b1;
                            led_cmd_pkg::GREEN_DISABLE:   rgb_enable[1] <= 1'b0;
                            led_cmd_pkg::BLUE_ENABLE:     rgb_enable[2] <= 1'b1;
                            led_cmd_pkg::BLUE_DISABLE:    rgb_enable[2] <= 1'b0;
                            led_cmd_pkg::BRIGHTNESS_ZERO: brightness_enable <= '0;
                            led_cmd_pkg::BRIGHTNESS_ONE,
                            led_cmd_pkg::BRIGHTNESS_TWO,
                            led_cmd_pkg::BRIGHTNESS_THREE,
                            led_cmd_pkg::BRIGHTNESS_FOUR,
                            led_cmd_pkg::BRIGHTNESS_FIVE,
                            led_cmd_pkg::BRIGHTNESS_SIX: begin
                                brightness_enable <= brightness_enable ^ toggle_mask;
                            end
                            led_cmd_pkg::BRIGHTNESS_NINE: brightness_enable <= '1;
                            led_cmd_pkg::READBRIGHTNESS:  state <= BRIGHTNESS;
                            led_cmd_pkg::BLANKPANEL,
                            led_cmd_pkg::FILLPANEL:       state <= FILL;
                            led_cmd_pkg::READPIXEL:       state <= PIXEL;
                            default: ;
                        endcase
                    end
                end
                BRIGHTNESS: begin
                    if (take) begin
                        brightness_enable <= rx_data[`LED_BRIGHTNESS_LEVELS-1:0];
                        state <= IDLE;
                    end
                end
                PIXEL: begin
                    if (pixel_done) begin
                        state <= IDLE;
                    end
                end
                FILL: begin
                    if (fill_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/led_cmd_pkg.sv */
/*
 * LED controller command set
 * Received byte type and the one-byte opcode encoding.
 */
package led_cmd_pkg;

    typedef logic [7:0] cmd_byte_t;

    typedef enum logic [7:0] {
        RED_ENABLE       = 8'h10,
        RED_DISABLE      = 8'h11,
        GREEN_ENABLE     = 8'h12,
        GREEN_DISABLE    = 8'h13,
        BLUE_ENABLE      = 8'h14,
        BLUE_DISABLE     = 8'h15,
        BRIGHTNESS_ZERO  = 8'h20,
        BRIGHTNESS_ONE   = 8'h21,
        BRIGHTNESS_TWO   = 8'h22,
        BRIGHTNESS_THREE = 8'h23,
        BRIGHTNESS_FOUR  = 8'h24,
        BRIGHTNESS_FIVE  = 8'h25,
        BRIGHTNESS_SIX   = 8'h26,
        BRIGHTNESS_NINE  = 8'h29,
        // argument byte follows
        READBRIGHTNESS   = 8'h30,
        BLANKPANEL       = 8'h40,
        FILLPANEL        = 8'h41,
        READPIXEL        = 8'h42
    } opcode_e;

endpackage

/* logic/led_ctrl_config.svh */
/*
 * LED matrix controller configuration
 * Panel geometry, frame buffer byte layout and brightness depth.
 */
`ifndef LED_CTRL_CONFIG_SVH
`define LED_CTRL_CONFIG_SVH

// panel size in pixels
`define LED_ROWS 8
`define LED_COLS 16
`define LED_BYTES_PER_PIXEL 2

// bit planes per colour
`define LED_BRIGHTNESS_LEVELS 6

// address field widths
`define LED_ROW_BITS 3
`define LED_COL_BITS 4
`define LED_BYTE_BITS 1

`endif

/* logic/led_ctrl_top.sv */
/*
 * LED matrix controller front end
 * Byte stream in, Wishbone frame buffer writes out.
 */
`timescale 1ns/1ps

module led_ctrl_top (
    input  logic                    clk_in,
    input  logic                    reset,
    input  led_cmd_pkg::cmd_byte_t  rx_data,
    input  logic                    rx_valid,
    output logic                    rx_ready,
    output logic                    busy,
    output logic [2:0]              rgb_enable,
    output led_fb_pkg::brightness_t brightness_enable,
    output logic                    fb_cyc,
    output logic                    fb_stb,
    output logic                    fb_we,
    output led_fb_pkg::fb_addr_t    fb_adr,
    output led_fb_pkg::fb_data_t    fb_dat,
    input  logic                    fb_ack
);
    led_cmd_pkg::cmd_byte_t byte_data;
    logic pixel_start, pixel_byte, pixel_ready, pixel_done;
    logic fill_start, blank_start, fill_byte, fill_ready, fill_done;
    logic m0_cyc, m0_stb, m0_ack;
    logic m1_cyc, m1_stb, m1_ack;
    led_fb_pkg::fb_addr_t m0_adr, m1_adr;
    led_fb_pkg::fb_data_t m0_dat, m1_dat;

    led_cmd_dispatch i_dispatch (
        .clk_in(clk_in), .reset(reset),
        .rx_data(rx_data), .rx_valid(rx_valid), .rx_ready(rx_ready),
        .pixel_ready(pixel_ready), .pixel_done(pixel_done),
        .fill_ready(fill_ready), .fill_done(fill_done),
        .busy(busy), .rgb_enable(rgb_enable), .brightness_enable(brightness_enable),
        .byte_data(byte_data), .pixel_start(pixel_start), .pixel_byte(pixel_byte),
        .fill_start(fill_start), .blank_start(blank_start), .fill_byte(fill_byte)
    );

    // master 0
    pixel_writer i_pixel (
        .clk_in(clk_in), .reset(reset),
        .start(pixel_start), .byte_strobe(pixel_byte), .byte_data(byte_data),
        .ready(pixel_ready), .done(pixel_done),
        .wb_cyc(m0_cyc), .wb_stb(m0_stb), .wb_adr(m0_adr), .wb_dat(m0_dat),
        .wb_ack(m0_ack)
    );

    // master 1
    panel_filler i_filler (
        .clk_in(clk_in), .reset(reset),
        .fill_start(fill_start), .blank_start(blank_start),
        .byte_strobe(fill_byte), .byte_data(byte_data),
        .ready(fill_ready), .done(fill_done),
        .wb_cyc(m1_cyc), .wb_stb(m1_stb), .wb_adr(m1_adr), .wb_dat(m1_dat),
        .wb_ack(m1_ack)
    );

    fb_bus_arbiter i_arbiter (
        .clk_in(clk_in), .reset(reset),
        .m0_cyc(m0_cyc), .m0_stb(m0_stb), .m0_adr(m0_adr), .m0_dat(m0_dat), .m0_ack(m0_ack),
        .m1_cyc(m1_cyc), .m1_stb(m1_stb), .m1_adr(m1_adr), .m1_dat(m1_dat), .m1_ack(m1_ack),
        .fb_cyc(fb_cyc), .fb_stb(fb_stb), .fb_we(fb_we),
        .fb_adr(fb_adr), .fb_dat(fb_dat), .fb_ack(fb_ack)
    );

endmodule

/* logic/led_fb_pkg.sv */
/*
 * Frame buffer types
 * Address fields, data byte and brightness mask.
 */
`include "led_ctrl_config.svh"

package led_fb_pkg;

    typedef logic [`LED_ROW_BITS-1:0] row_addr_t;
    typedef logic [`LED_COL_BITS-1:0] col_addr_t;
    typedef logic [`LED_BYTE_BITS-1:0] byte_idx_t;

    // {row, col, ~byte index}
    typedef logic [`LED_ROW_BITS+`LED_COL_BITS+`LED_BYTE_BITS-1:0] fb_addr_t;

    typedef logic [7:0] fb_data_t;
    typedef logic [`LED_BRIGHTNESS_LEVELS-1:0] brightness_t;

endpackage

/* logic/panel_filler.sv */
/*
 * Panel filler
 * Writes the fill colour, or zero for blank, to every frame buffer byte.
 */
`timescale 1ns/1ps
`include "led_ctrl_config.svh"

module panel_filler (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   fill_start,
    input  logic                   blank_start,
    input  logic                   byte_strobe,
    input  led_cmd_pkg::cmd_byte_t byte_data,
    output logic                   ready,
    output logic                   done,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output led_fb_pkg::fb_addr_t   wb_adr,
    output led_fb_pkg::fb_data_t   wb_dat,
    input  logic                   wb_ack
);
    typedef enum logic [1:0] {
        F_IDLE,
        F_COLLECT,
        F_WRITE,
        F_NEXT
    } fill_state_e;

    localparam int FB_BYTES = `LED_ROWS * `LED_COLS * `LED_BYTES_PER_PIXEL;
    localparam led_fb_pkg::fb_addr_t LAST_ADDR = led_fb_pkg::fb_addr_t'(FB_BYTES - 1);
    localparam led_fb_pkg::byte_idx_t LAST_BYTE =
        led_fb_pkg::byte_idx_t'(`LED_BYTES_PER_PIXEL - 1);

    fill_state_e state;
    led_fb_pkg::fb_data_t colour [`LED_BYTES_PER_PIXEL];
    led_fb_pkg::byte_idx_t collect_idx;
    led_fb_pkg::byte_idx_t adr_idx;
    led_fb_pkg::fb_addr_t adr;

    // byte index sits inverted in the address lsbs
    assign adr_idx = ~adr[`LED_BYTE_BITS-1:0];

    assign ready = (state == F_COLLECT);
    assign done = (state == F_WRITE) && wb_ack && (adr == LAST_ADDR);
    assign wb_cyc = (state == F_WRITE);
    assign wb_stb = wb_cyc;
    assign wb_adr = adr;
    assign wb_dat = colour[adr_idx];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= F_IDLE;
        end else begin
            case (state)
                F_IDLE: begin
                    if (fill_start) begin
                        state <= F_COLLECT;
                    end else if (blank_start) begin
                        state <= F_WRITE;
                    end
                end
                F_COLLECT: if (byte_strobe && collect_idx == LAST_BYTE) state <= F_WRITE;
                F_WRITE:   if (wb_ack) state <= (adr == LAST_ADDR) ? F_IDLE : F_NEXT;
                // one idle cycle between single writes
                F_NEXT:    state <= F_WRITE;
                default:   state <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (state == F_IDLE) begin
            collect_idx <= '0;
            adr <= '0;
            if (blank_start) begin
                colour <= '{default: '0};
            end
        end
        if (state == F_COLLECT && byte_strobe) begin
            colour[collect_idx] <= byte_data;
            collect_idx <= collect_idx + 1'b1;
        end
        if (state == F_WRITE && wb_ack) begin
            adr <= adr + 1'b1;
        end
    end

endmodule

/* logic/pixel_writer.sv */
/*
 * Single pixel writer
 * Takes row, column and colour bytes, writes each colour byte over Wishbone.
 */
`timescale 1ns/1ps
`include "led_ctrl_config.svh"

module pixel_writer (
    input  logic                   clk_in,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   byte_strobe,
    input  led_cmd_pkg::cmd_byte_t byte_data,
    output logic                   ready,
    output logic                   done,
    output logic                   wb_cyc,
    output logic                   wb_stb,
    output led_fb_pkg::fb_addr_t   wb_adr,
    output led_fb_pkg::fb_data_t   wb_dat,
    input  logic                   wb_ack
);
    typedef enum logic [2:0] {
        P_IDLE,
        P_ROW,
        P_COL,
        P_COLOUR,
        P_WRITE
    } pix_state_e;

    localparam led_fb_pkg::byte_idx_t LAST_BYTE =
        led_fb_pkg::byte_idx_t'(`LED_BYTES_PER_PIXEL - 1);

    pix_state_e state;
    led_fb_pkg::row_addr_t row;
    led_fb_pkg::col_addr_t col;
    led_fb_pkg::byte_idx_t byte_idx;
    led_fb_pkg::fb_data_t colour;
    logic last_byte;

    assign last_byte = (byte_idx == LAST_BYTE);
    assign ready = (state == P_ROW) || (state == P_COL) || (state == P_COLOUR);
    assign done = (state == P_WRITE) && wb_ack && last_byte;
    assign wb_cyc = (state == P_WRITE);
    assign wb_stb = wb_cyc;
    // first colour byte goes to the odd address
    assign wb_adr = {row, col, ~byte_idx};
    assign wb_dat = colour;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            state <= P_IDLE;
        end else begin
            case (state)
                P_IDLE:   if (start) state <= P_ROW;
                P_ROW:    if (byte_strobe) state <= P_COL;
                P_COL:    if (byte_strobe) state <= P_COLOUR;
                P_COLOUR: if (byte_strobe) state <= P_WRITE;
                P_WRITE:  if (wb_ack) state <= last_byte ? P_IDLE : P_COLOUR;
                default:  state <= P_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (byte_strobe && state == P_ROW) begin
            row <= byte_data[`LED_ROW_BITS-1:0];
        end
        if (byte_strobe && state == P_COL) begin
            col <= byte_data[`LED_COL_BITS-1:0];
            byte_idx <= '0;
        end
        if (byte_strobe && state == P_COLOUR) begin
            colour <= byte_data;
        end
        if (wb_ack && state == P_WRITE && !last_byte) begin
            byte_idx <= byte_idx + 1'b1;
        end
    end

endmodule

/* tb/led_ctrl_assert.sv */
/*
 * LED controller bus checks
 * Wishbone hold rules and busy versus writer opcodes.
 */
`timescale 1ns/1ps

module led_ctrl_assert (
    input logic                   clk_in,
    input logic                   reset,
    input led_cmd_pkg::cmd_byte_t rx_data,
    input logic                   rx_valid,
    input logic                   rx_ready,
    input logic                   busy,
    input logic                   fb_cyc,
    input logic                   fb_stb,
    input led_fb_pkg::fb_addr_t   fb_adr,
    input led_fb_pkg::fb_data_t   fb_dat,
    input logic                   fb_ack
);
    logic writer_op;

    assign writer_op = rx_valid && rx_ready
                       && (rx_data == led_cmd_pkg::BLANKPANEL
                           || rx_data == led_cmd_pkg::FILLPANEL
                           || rx_data == led_cmd_pkg::READPIXEL);

    // single writes close the cycle right after ack
    cycle_ends_after_ack: assert property (@(posedge clk_in) disable iff (reset)
        fb_stb && fb_ack |=> !fb_cyc && !fb_stb)
        else $error("bus cycle still open after its ack");

    // master holds the write until ack
    hold_until_ack: assert property (@(posedge clk_in) disable iff (reset)
        fb_stb && !fb_ack |=> $stable(fb_adr) && $stable(fb_dat))
        else $error("fb_adr or fb_dat changed before ack");

    busy_from_opcode: assert property (@(posedge clk_in) disable iff (reset)
        $rose(busy) |-> $past(writer_op))
        else $error("busy rose without a writer opcode");

endmodule

bind led_ctrl_top led_ctrl_assert i_assert (
    .clk_in(clk_in),
    .reset(reset),
    .rx_data(rx_data),
    .rx_valid(rx_valid),
    .rx_ready(rx_ready),
    .busy(busy),
    .fb_cyc(fb_cyc),
    .fb_stb(fb_stb),
    .fb_adr(fb_adr),
    .fb_dat(fb_dat),
    .fb_ack(fb_ack)
);

/* tb/led_ctrl_tb.sv */
/*
 * LED controller testbench
 * Replays the vector file against the DUT and a Wishbone frame buffer model.
 */
`timescale 1ns/1ps
`include "led_ctrl_config.svh"

module led_ctrl_tb;
    localparam int FB_BYTES = `LED_ROWS * `LED_COLS * `LED_BYTES_PER_PIXEL;
    localparam string VECTOR_FILE = "tb/led_ctrl_vectors.txt";

    logic clk_in;
    logic reset;
    led_cmd_pkg::cmd_byte_t rx_data;
    logic rx_valid;
    logic rx_ready;
    logic busy;
    logic [2:0] rgb_enable;
    led_fb_pkg::brightness_t brightness_enable;
    logic fb_cyc;
    logic fb_stb;
    logic fb_we;
    led_fb_pkg::fb_addr_t fb_adr;
    led_fb_pkg::fb_data_t fb_dat;
    logic fb_ack = 1'b0;

    led_fb_pkg::fb_data_t mem [FB_BYTES];
    integer seed = 32'ha9f;
    int ack_wait = 0;
    int ack_delay = 0;
    int cycles = 0;
    int cycle_limit = 0;

    byte kind_q[$];
    string name_q[$];
    int arg0_q[$];
    int arg1_q[$];

    string test_name = "";
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit named [FB_BYTES];
    bit bad_run = 1'b0;

    led_ctrl_top i_dut (
        .clk_in(clk_in),
        .reset(reset),
        .rx_data(rx_data),
        .rx_valid(rx_valid),
        .rx_ready(rx_ready),
        .busy(busy),
        .rgb_enable(rgb_enable),
        .brightness_enable(brightness_enable),
        .fb_cyc(fb_cyc),
        .fb_stb(fb_stb),
        .fb_we(fb_we),
        .fb_adr(fb_adr),
        .fb_dat(fb_dat),
        .fb_ack(fb_ack)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    // frame buffer model with 0 to 3 wait states per write
    always @(negedge clk_in) begin
        if (reset) begin
            fb_ack <= 1'b0;
            for (int a = 0; a < FB_BYTES; a++) begin
                mem[a] <= 8'(a * 37 + 11);
            end
        end else if (fb_ack) begin
            fb_ack <= 1'b0;
        end else if (fb_cyc && fb_stb && fb_we) begin
            if (ack_wait >= ack_delay) begin
                fb_ack <= 1'b1;
                mem[fb_adr] <= fb_dat;
                ack_wait <= 0;
                ack_delay <= $unsigned($random(seed)) % 4;
            end else begin
                ack_wait <= ack_wait + 1;
            end
        end
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: run stopped after %0d cycles", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic read_vectors();
        int fd;
        int n;
        int a0;
        int a1;
        string line;
        string rest;
        fd = $fopen(VECTOR_FILE, "r");
        if (fd == 0) begin
            $display("cannot open vector file %s", VECTOR_FILE);
            bad_run = 1'b1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
                rest = line.substr(2, line.len() - 1);
                // strip line end from names
                while (rest.len() > 0 && (rest.getc(rest.len() - 1) == "\n"
                       || rest.getc(rest.len() - 1) == "\r"
                       || rest.getc(rest.len() - 1) == " ")) begin
                    rest = rest.substr(0, rest.len() - 2);
                end
                a0 = 0;
                a1 = 0;
                if (line.getc(0) != "T" && rest.len() > 0) begin
                    n = $sscanf(rest, "%h %h", a0, a1);
                end
                kind_q.push_back(line.getc(0));
                name_q.push_back(rest);
                arg0_q.push_back(a0);
                arg1_q.push_back(a1);
            end
        end
        $fclose(fd);
    endtask

    // called on a falling edge, returns on the falling edge after the byte is taken
    task automatic send_byte(input led_cmd_pkg::cmd_byte_t value);
        logic taken;
        rx_data = value;
        rx_valid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            taken = rx_ready;
            @(negedge clk_in);
        end
        rx_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(negedge clk_in);
        end
    endtask

    task automatic finish_test();
        if (test_name != "") begin
            if (errors == 0) begin
                $display("PASS %s", test_name);
                tests_passed++;
            end else begin
                $display("%s failed with %0d errors", test_name, errors);
                tests_failed++;
            end
        end
        errors = 0;
    endtask

    initial begin
        int fills;
        int idx;
        logic [7:0] v0;
        logic [7:0] v1;
        logic [7:0] expected;
        rx_data = '0;
        rx_valid = 1'b0;
        reset = 1'b1;
        read_vectors();
        fills = 0;
        for (idx = 0; idx < kind_q.size(); idx++) begin
            if (kind_q[idx] == "S" && (arg0_q[idx] == 'h40 || arg0_q[idx] == 'h41)) begin
                fills++;
            end
        end
        cycle_limit = 20 * kind_q.size() + 1100 * fills + 10;
        repeat (3) @(posedge clk_in);
        @(negedge clk_in);
        reset = 1'b0;
        if (busy !== 1'b0 || fb_cyc !== 1'b0 || fb_stb !== 1'b0 || fb_we !== 1'b0
            || rx_ready !== 1'b1) begin
            $display("busy, fb_cyc, fb_stb, fb_we or rx_ready wrong after reset");
            bad_run = 1'b1;
        end
        for (idx = 0; idx < kind_q.size(); idx++) begin
            v0 = arg0_q[idx][7:0];
            v1 = arg1_q[idx][7:0];
            case (kind_q[idx])
                "T": begin
                    finish_test();
                    test_name = name_q[idx];
                    named = '{default: 1'b0};
                end
                "S": send_byte(v0);
                "W": wait_idle();
                "R": begin
                    if (rgb_enable !== v0[2:0]) begin
                        $display("FAIL %s rgb_enable: expected %b, actual %b",
                                 test_name, v0[2:0], rgb_enable);
                        errors++;
                    end
                end
                "B": begin
                    if (brightness_enable !== v0[`LED_BRIGHTNESS_LEVELS-1:0]) begin
                        $display("FAIL %s brightness_enable: expected %b, actual %b",
                                 test_name, v0[`LED_BRIGHTNESS_LEVELS-1:0], brightness_enable);
                        errors++;
                    end
                end
                "M": begin
                    named[v0] = 1'b1;
                    if (mem[v0] !== v1) begin
                        $display("FAIL %s mem[%02h]: expected %02h, actual %02h",
                                 test_name, v0, v1, mem[v0]);
                        errors++;
                    end
                end
                "P": begin
                    for (int a = 0; a < FB_BYTES; a++) begin
                        expected = a[0] ? v0 : v1;
                        if (!named[a] && mem[a] !== expected) begin
                            $display("FAIL %s mem[%02h]: expected %02h, actual %02h",
                                     test_name, a, expected, mem[a]);
                            errors++;
                        end
                    end
                end
                default: begin
                    $display("unknown vector line kind %c", kind_q[idx]);
                    bad_run = 1'b1;
                end
            endcase
        end
        finish_test();
        $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0 && !bad_run && tests_passed > 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb/led_ctrl_vectors.txt */
# T name | S byte to send | W wait until busy low | R rgb_enable | B brightness_enable
# M addr byte | P odd even: every byte not named by M in the test, by address parity
T reset_state
R 7
B 3f
T colour_bits
S 11
R 6
S 15
R 2
S 13
R 0
S 14
R 4
S 12
R 6
S 10
R 7
T brightness_bits
S 21
B 1f
S 26
B 1e
S 23
B 16
S 20
B 0
S 29
B 3f
S 30
S 2a
B 2a
T fill_panel
S 41
S 12
S 34
W
P 12 34
T blank_panel
S 40
W
P 0 0
T read_pixel
S 42
S 3
S 5
S ab
S cd
W
M 6b ab
M 6a cd
P 0 0
T pixel_after_fill
S 41
S 55
S 66
S 42
S 7
S f
S 9a
S bc
W
M ff 9a
M fe bc
P 55 66
